//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_be_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/be_calculator.sv
// Two-stage execute pipeline. It never stalls.
// Stage 1 runs the ALU and issues the memory command.
// Stage 2 takes the memory response and registers the commit.
// Memory addresses are rs1 plus imm, cut to the data memory width.

`timescale 1ns/1ps

module be_calculator
   import be_pkg::*;
   (input  logic          clk_i
    , input  logic          arst_n_i

    , input  dispatch_pkt_s dispatch_pkt_i
    , input  logic          dispatch_v_i

    , output reg_addr_t     ex_rd_o
    , output logic          ex_v_o

    , output mmu_cmd_s      mmu_cmd_o
    , output logic          mmu_cmd_v_o
    , input  logic          mmu_cmd_ready_i
    , input  mem_resp_s     mem_resp_i

    , output wb_pkt_s       wb_pkt_o
    , output logic          wb_v_o

    , output commit_pkt_s   commit_pkt_o
    , output logic          commit_v_o
    );

   dword_t      alu_result;
   dword_t      addr_sum;
   logic        mem_op;
   commit_pkt_s ex_pkt_r;
   logic        ex_v_r;
   logic        ex_rsp_v_r;
   commit_pkt_s commit_pkt_r;
   logic        commit_v_r;

   // STORE carries its store data through as the result
   always_comb begin
      unique case (dispatch_pkt_i.op)
         e_op_add:   alu_result = dispatch_pkt_i.rs1_val + dispatch_pkt_i.rs2_val;
         e_op_sub:   alu_result = dispatch_pkt_i.rs1_val - dispatch_pkt_i.rs2_val;
         e_op_and:   alu_result = dispatch_pkt_i.rs1_val & dispatch_pkt_i.rs2_val;
         e_op_xor:   alu_result = dispatch_pkt_i.rs1_val ^ dispatch_pkt_i.rs2_val;
         e_op_addi:  alu_result = dispatch_pkt_i.rs1_val + dispatch_pkt_i.imm;
         e_op_store: alu_result = dispatch_pkt_i.rs2_val;
         default:    alu_result = '0;
      endcase
   end

   assign mem_op   = dispatch_pkt_i.op inside {e_op_load, e_op_store, e_op_rdcnt};
   assign addr_sum = dispatch_pkt_i.rs1_val + dispatch_pkt_i.imm;

   assign mmu_cmd_o   = '{w_v:  (dispatch_pkt_i.op == e_op_store),
                          addr: addr_sum[$bits(dmem_addr_t)-1:0],
                          data: dispatch_pkt_i.rs2_val};
   assign mmu_cmd_v_o = dispatch_v_i & mem_op;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ex_v_r     <= 1'b0;
         ex_rsp_v_r <= 1'b0;
         commit_v_r <= 1'b0;
      end else begin
         ex_v_r     <= dispatch_v_i;
         // Loads and RDCNT take their result from the memory block
         ex_rsp_v_r <= mmu_cmd_v_o & mmu_cmd_ready_i & (dispatch_pkt_i.op != e_op_store);
         commit_v_r <= ex_v_r;
      end
   end

   always_ff @(posedge clk_i) begin
      if (dispatch_v_i) begin
         ex_pkt_r <= '{pc:   dispatch_pkt_i.pc,
                       op:   dispatch_pkt_i.op,
                       rd:   dispatch_pkt_i.rd,
                       data: alu_result};
      end
      if (ex_v_r) begin
         commit_pkt_r      <= ex_pkt_r;
         commit_pkt_r.data <= ex_rsp_v_r ? mem_resp_i.data : ex_pkt_r.data;
      end
   end

   assign ex_rd_o = ex_pkt_r.rd;
   assign ex_v_o  = ex_v_r & op_writes_rd(ex_pkt_r.op);

   assign wb_pkt_o = '{rd: commit_pkt_r.rd, data: commit_pkt_r.data};
   assign wb_v_o   = commit_v_r & op_writes_rd(commit_pkt_r.op) & (commit_pkt_r.rd != '0);

   assign commit_pkt_o = commit_pkt_r;
   assign commit_v_o   = commit_v_r;

endmodule

//--- hdl/be_checker.sv
// Register file, hazard check and dispatch.
// No forwarding: a source waits until its producer has left writeback.
// Dispatch is one cycle wide and is never back-pressured.
// The front-end queue holds its head entry stable until yumi.

`timescale 1ns/1ps

module be_checker
   import be_pkg::*;
   (input  logic          clk_i
    , input  logic          arst_n_i

    , input  fe_queue_s     fe_queue_i
    , input  logic          fe_queue_v_i
    , output logic          fe_queue_yumi_o

    , output dispatch_pkt_s dispatch_pkt_o
    , output logic          dispatch_v_o

    , input  reg_addr_t     ex_rd_i
    , input  logic          ex_v_i

    , input  wb_pkt_s       wb_pkt_i
    , input  logic          wb_v_i
    );

   dword_t        rf_r [reg_count_lp];
   dispatch_pkt_s dispatch_pkt_r;
   logic          dispatch_v_r;
   logic          disp_wr_v;
   reg_addr_t     busy_rd [3];
   logic [2:0]    busy_v;
   logic          use_rs1;
   logic          use_rs2;
   logic          rs1_hit;
   logic          rs2_hit;
   logic          hazard;
   logic          yumi;

   // Destination held in the dispatch register
   assign disp_wr_v = dispatch_v_r & op_writes_rd(dispatch_pkt_r.op);

   assign use_rs1 = (fe_queue_i.op != e_op_rdcnt);
   assign use_rs2 = fe_queue_i.op inside {e_op_add, e_op_sub, e_op_and, e_op_xor, e_op_store};

   // Compare head sources against dispatch, stage 1 and writeback
   always_comb begin
      busy_rd[0] = dispatch_pkt_r.rd;
      busy_rd[1] = ex_rd_i;
      busy_rd[2] = wb_pkt_i.rd;
      busy_v     = {wb_v_i, ex_v_i, disp_wr_v};
      rs1_hit    = 1'b0;
      rs2_hit    = 1'b0;
      for (int i = 0; i < 3; i++) begin
         rs1_hit |= busy_v[i] && (busy_rd[i] == fe_queue_i.rs1);
         rs2_hit |= busy_v[i] && (busy_rd[i] == fe_queue_i.rs2);
      end
   end

   assign hazard = (use_rs1 && rs1_hit && (fe_queue_i.rs1 != '0))
                 | (use_rs2 && rs2_hit && (fe_queue_i.rs2 != '0));

   assign yumi = fe_queue_v_i & ~hazard;

   // r0 is never written, so it stays zero
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < reg_count_lp; i++) begin
            rf_r[i] <= '0;
         end
      end else if (wb_v_i && (wb_pkt_i.rd != '0)) begin
         rf_r[wb_pkt_i.rd] <= wb_pkt_i.data;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dispatch_v_r <= 1'b0;
      end else begin
         dispatch_v_r <= yumi;
      end
   end

   // Operands read from the register file as it stands this cycle
   always_ff @(posedge clk_i) begin
      if (yumi) begin
         dispatch_pkt_r <= '{pc:      fe_queue_i.pc,
                             op:      fe_queue_i.op,
                             rd:      fe_queue_i.rd,
                             rs1_val: rf_r[fe_queue_i.rs1],
                             rs2_val: rf_r[fe_queue_i.rs2],
                             imm:     fe_queue_i.imm};
      end
   end

   assign fe_queue_yumi_o = yumi;
   assign dispatch_pkt_o  = dispatch_pkt_r;
   assign dispatch_v_o    = dispatch_v_r;

endmodule

//--- hdl/be_mem.sv
// Small data memory plus the retire counter.
// Always ready; responses come one cycle after the command.
// RDCNT also counts a commit in the response cycle, so the value
// matches the number of instructions retired before it.

`timescale 1ns/1ps

module be_mem
   import be_pkg::*;
   (input  logic      clk_i
    , input  logic      arst_n_i

    , input  mmu_cmd_s  mmu_cmd_i
    , input  logic      mmu_cmd_v_i
    , input  be_op_e    mmu_cmd_op_i
    , output logic      mmu_cmd_ready_o

    , output mem_resp_s mem_resp_o

    , input  logic      commit_v_i
    );

   dword_t mem_r [dmem_words_lp];
   dword_t rdata_r;
   be_op_e op_r;
   dword_t retire_cnt_r;
   logic   cmd_fire;

   assign mmu_cmd_ready_o = 1'b1;
   assign cmd_fire        = mmu_cmd_v_i & mmu_cmd_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < dmem_words_lp; i++) begin
            mem_r[i] <= '0;
         end
      end else if (cmd_fire && mmu_cmd_i.w_v) begin
         mem_r[mmu_cmd_i.addr] <= mmu_cmd_i.data;
      end
   end

   // Registered read that sees a store only on the next command
   always_ff @(posedge clk_i) begin
      if (cmd_fire) begin
         rdata_r <= mem_r[mmu_cmd_i.addr];
         op_r    <= mmu_cmd_op_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         retire_cnt_r <= '0;
      end else if (commit_v_i) begin
         retire_cnt_r <= retire_cnt_r + dword_t'(1);
      end
   end

   // Counter read includes the commit of this same cycle
   assign mem_resp_o.data = (op_r == e_op_rdcnt)
                          ? retire_cnt_r + dword_t'(commit_v_i)
                          : rdata_r;

endmodule

//--- hdl/be_pkg.sv
// Shared widths, opcodes and packets for the in-order back end.
// All sizes are fixed at 16-bit data, 8 registers and 16 memory words.
// r0 reads zero, and STORE is the only op that leaves rd unwritten.

package be_pkg;

   localparam int dword_width_lp = 16;
   localparam int reg_count_lp   = 8;
   localparam int pc_width_lp    = 8;
   localparam int dmem_words_lp  = 16;

   typedef logic [dword_width_lp-1:0]         dword_t;
   typedef logic [$clog2(reg_count_lp)-1:0]   reg_addr_t;
   typedef logic [pc_width_lp-1:0]            pc_t;
   typedef logic [$clog2(dmem_words_lp)-1:0]  dmem_addr_t;

   typedef enum logic [2:0] {
      e_op_add   = 3'd0,
      e_op_sub   = 3'd1,
      e_op_and   = 3'd2,
      e_op_xor   = 3'd3,
      e_op_addi  = 3'd4,
      e_op_load  = 3'd5,
      e_op_store = 3'd6,
      e_op_rdcnt = 3'd7
   } be_op_e;

   // Pre-decoded entry from the front-end queue
   typedef struct packed {
      pc_t       pc;
      be_op_e    op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      dword_t    imm;
   } fe_queue_s;

   typedef struct packed {
      pc_t       pc;
      be_op_e    op;
      reg_addr_t rd;
      dword_t    rs1_val;
      dword_t    rs2_val;
      dword_t    imm;
   } dispatch_pkt_s;

   typedef struct packed {
      logic       w_v;
      dmem_addr_t addr;
      dword_t     data;
   } mmu_cmd_s;

   typedef struct packed {
      dword_t data;
   } mem_resp_s;

   typedef struct packed {
      reg_addr_t rd;
      dword_t    data;
   } wb_pkt_s;

   typedef struct packed {
      pc_t       pc;
      be_op_e    op;
      reg_addr_t rd;
      dword_t    data;
   } commit_pkt_s;

   function automatic logic op_writes_rd(input be_op_e op);
      return op != e_op_store;
   endfunction

endpackage

//--- hdl/be_top.sv
// Back-end top level wiring the checker, calculator and memory.
// The front-end queue source must hold its entry until yumi.
// Commits leave in program order with no back-pressure.

`timescale 1ns/1ps

module be_top
   import be_pkg::*;
   (input  logic        clk_i
    , input  logic        arst_n_i

    , input  fe_queue_s   fe_queue_i
    , input  logic        fe_queue_v_i
    , output logic        fe_queue_yumi_o

    , output commit_pkt_s commit_pkt_o
    , output logic        commit_v_o
    );

   dispatch_pkt_s dispatch_pkt;
   logic          dispatch_v;
   reg_addr_t     ex_rd;
   logic          ex_v;
   mmu_cmd_s      mmu_cmd;
   logic          mmu_cmd_v;
   logic          mmu_cmd_ready;
   mem_resp_s     mem_resp;
   wb_pkt_s       wb_pkt;
   logic          wb_v;

   be_checker be_checker
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.fe_queue_i(fe_queue_i)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.dispatch_pkt_o(dispatch_pkt)
      ,.dispatch_v_o(dispatch_v)
      ,.ex_rd_i(ex_rd)
      ,.ex_v_i(ex_v)
      ,.wb_pkt_i(wb_pkt)
      ,.wb_v_i(wb_v)
      );

   be_calculator be_calculator
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.dispatch_pkt_i(dispatch_pkt)
      ,.dispatch_v_i(dispatch_v)
      ,.ex_rd_o(ex_rd)
      ,.ex_v_o(ex_v)
      ,.mmu_cmd_o(mmu_cmd)
      ,.mmu_cmd_v_o(mmu_cmd_v)
      ,.mmu_cmd_ready_i(mmu_cmd_ready)
      ,.mem_resp_i(mem_resp)
      ,.wb_pkt_o(wb_pkt)
      ,.wb_v_o(wb_v)
      ,.commit_pkt_o(commit_pkt_o)
      ,.commit_v_o(commit_v_o)
      );

   // Op comes from the dispatch packet that issues the command
   be_mem be_mem
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.mmu_cmd_i(mmu_cmd)
      ,.mmu_cmd_v_i(mmu_cmd_v)
      ,.mmu_cmd_op_i(dispatch_pkt.op)
      ,.mmu_cmd_ready_o(mmu_cmd_ready)
      ,.mem_resp_o(mem_resp)
      ,.commit_v_i(commit_v_o)
      );

endmodule

//--- sources.f
hdl/be_pkg.sv
hdl/be_checker.sv
hdl/be_calculator.sv
hdl/be_mem.sv
hdl/be_top.sv
tb/tb_commit_checker.sv
tb/tb_be_top.sv

//--- tb/tb_be_top.sv
// Testbench for be_top. A fixed program from a table goes through the
// front-end queue with random gaps; tb_commit_checker compares commits.
// Expected data is worked out by hand from zeroed registers and memory.

`timescale 1ns/1ps

module tb_be_top
   import be_pkg::*;
   ();

   localparam int rows_lp         = 22;
   localparam int yumi_timeout_lp = 20;
   localparam int done_timeout_lp = 1000;

   logic        clk;
   logic        arst_n;
   fe_queue_s   fe_queue;
   logic        fe_queue_v;
   logic        fe_queue_yumi;
   commit_pkt_s commit_pkt;
   logic        commit_v;

   fe_queue_s   instr_tbl [rows_lp];
   dword_t      exp_data [rows_lp];
   logic        check_done;
   int          mismatch_cnt;
   int          timeout_cnt;
   int          protocol_cnt;
   int          drive_err_cnt = 0;
   int          seed;

   be_top dut
     (.clk_i(clk)
      ,.arst_n_i(arst_n)
      ,.fe_queue_i(fe_queue)
      ,.fe_queue_v_i(fe_queue_v)
      ,.fe_queue_yumi_o(fe_queue_yumi)
      ,.commit_pkt_o(commit_pkt)
      ,.commit_v_o(commit_v)
      );

   tb_commit_checker #(.rows_p(rows_lp)) commit_checker
     (.clk_i(clk)
      ,.arst_n_i(arst_n)
      ,.fe_queue_yumi_i(fe_queue_yumi)
      ,.commit_v_i(commit_v)
      ,.commit_pkt_i(commit_pkt)
      ,.instr_tbl_i(instr_tbl)
      ,.exp_data_i(exp_data)
      ,.done_o(check_done)
      ,.mismatch_cnt_o(mismatch_cnt)
      ,.timeout_cnt_o(timeout_cnt)
      ,.protocol_cnt_o(protocol_cnt)
      );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic set_row(input int row, input pc_t pc, input be_op_e op,
                          input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                          input dword_t imm, input dword_t exp);
      instr_tbl[row] = '{pc: pc, op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
      exp_data[row]  = exp;
   endtask

   // row, pc, op, rd, rs1, rs2, imm, expected commit data
   task automatic load_table();
      set_row( 0, 8'h00, e_op_addi,  3'd1, 3'd0, 3'd0, 16'h0005, 16'h0005);
      set_row( 1, 8'h04, e_op_addi,  3'd2, 3'd0, 3'd0, 16'hfffe, 16'hfffe);
      set_row( 2, 8'h08, e_op_add,   3'd3, 3'd1, 3'd2, 16'h0000, 16'h0003);
      set_row( 3, 8'h0c, e_op_sub,   3'd4, 3'd1, 3'd2, 16'h0000, 16'h0007);
      set_row( 4, 8'h10, e_op_and,   3'd5, 3'd3, 3'd4, 16'h0000, 16'h0003);
      set_row( 5, 8'h14, e_op_xor,   3'd6, 3'd5, 3'd2, 16'h0000, 16'hfffd);
      // Write to r0 is dropped and the next read of r0 gives zero
      set_row( 6, 8'h18, e_op_addi,  3'd0, 3'd1, 3'd0, 16'h0100, 16'h0105);
      set_row( 7, 8'h1c, e_op_add,   3'd7, 3'd0, 3'd1, 16'h0000, 16'h0005);
      set_row( 8, 8'h20, e_op_rdcnt, 3'd7, 3'd0, 3'd0, 16'h0000, 16'h0008);
      set_row( 9, 8'h24, e_op_store, 3'd0, 3'd1, 3'd6, 16'h0003, 16'hfffd);
      set_row(10, 8'h28, e_op_store, 3'd0, 3'd2, 3'd4, 16'h0004, 16'h0007);
      set_row(11, 8'h2c, e_op_load,  3'd1, 3'd0, 3'd0, 16'h0008, 16'hfffd);
      set_row(12, 8'h30, e_op_load,  3'd3, 3'd0, 3'd0, 16'h0002, 16'h0007);
      // 0xfffe + 0x000a wraps to word 8
      set_row(13, 8'h34, e_op_load,  3'd5, 3'd2, 3'd0, 16'h000a, 16'hfffd);
      set_row(14, 8'h38, e_op_add,   3'd4, 3'd1, 3'd3, 16'h0000, 16'h0004);
      set_row(15, 8'h3c, e_op_load,  3'd6, 3'd0, 3'd0, 16'h0005, 16'h0000);
      set_row(16, 8'h40, e_op_xor,   3'd2, 3'd5, 3'd1, 16'h0000, 16'h0000);
      set_row(17, 8'h44, e_op_rdcnt, 3'd1, 3'd0, 3'd0, 16'h0000, 16'h0011);
      set_row(18, 8'h48, e_op_addi,  3'd3, 3'd1, 3'd0, 16'h0003, 16'h0014);
      set_row(19, 8'h4c, e_op_sub,   3'd5, 3'd0, 3'd3, 16'h0000, 16'hffec);
      set_row(20, 8'h50, e_op_store, 3'd0, 3'd0, 3'd5, 16'h001f, 16'hffec);
      set_row(21, 8'h54, e_op_load,  3'd7, 3'd3, 3'd0, 16'hfffb, 16'hffec);
   endtask

   initial begin
      int   gap;
      int   n;
      logic got;
      seed       = 32'h6cff;
      arst_n     = 1'b0;
      fe_queue   = '0;
      fe_queue_v = 1'b0;
      load_table();
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int row = 0; row < rows_lp; row++) begin
         gap = $random(seed) & 3;
         repeat (gap) @(negedge clk);
         fe_queue   = instr_tbl[row];
         fe_queue_v = 1'b1;
         // Entry held until the DUT takes it
         n   = 0;
         got = 1'b0;
         while (!got && n < yumi_timeout_lp) begin
            @(posedge clk);
            got = fe_queue_yumi;
            n++;
         end
         if (!got) begin
            $display("timeout at %0t: table row %0d was never consumed", $time, row);
            drive_err_cnt++;
         end
         @(negedge clk);
         fe_queue_v = 1'b0;
      end
      n = 0;
      while (!check_done && n < done_timeout_lp) begin
         @(posedge clk);
         n++;
      end
      if (!check_done) begin
         $display("timeout: the commit checker did not finish its comparisons");
         drive_err_cnt++;
      end
      $display("errors: %0d mismatch, %0d timeout, %0d protocol, %0d driver",
               mismatch_cnt, timeout_cnt, protocol_cnt, drive_err_cnt);
      if (mismatch_cnt + timeout_cnt + protocol_cnt + drive_err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- tb/tb_commit_checker.sv
// Watches the commit port and the front-end queue handshake of be_top.
// Commits are compared in table order against pc, op, rd and data.
// Outputs are sampled at the rising edge, before the DUT updates them.

`timescale 1ns/1ps

module tb_commit_checker
   import be_pkg::*;
   #(parameter int rows_p = 1)
   (input  logic          clk_i
    , input  logic          arst_n_i
    , input  logic          fe_queue_yumi_i
    , input  logic          commit_v_i
    , input  commit_pkt_s   commit_pkt_i
    , input  fe_queue_s     instr_tbl_i [rows_p]
    , input  dword_t        exp_data_i [rows_p]
    , output logic          done_o
    , output int            mismatch_cnt_o
    , output int            timeout_cnt_o
    , output int            protocol_cnt_o
    );

   localparam int commit_timeout_lp = 40;
   localparam int drain_cycles_lp   = 10;

   int   mismatch_cnt = 0;
   int   timeout_cnt  = 0;
   int   protocol_cnt = 0;
   int   yumi_cnt     = 0;
   int   commit_cnt   = 0;
   int   cycle        = 0;
   int   first_yumi   = -1;
   logic done         = 1'b0;

   task automatic compare_field(input string name, input dword_t got, input dword_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         mismatch_cnt++;
      end
   endtask

   // Every commit must follow a consumed entry
   always @(posedge clk_i) begin
      cycle++;
      if (!arst_n_i) begin
         if (fe_queue_yumi_i || commit_v_i) begin
            $display("error at %0t: yumi or commit valid is high during reset", $time);
            protocol_cnt++;
         end
      end else begin
         if (fe_queue_yumi_i) begin
            if (first_yumi < 0) begin
               first_yumi = cycle;
            end
            yumi_cnt++;
         end
         if (commit_v_i) begin
            if (commit_cnt >= yumi_cnt) begin
               $display("error at %0t: commit with no consumed entry behind it", $time);
               protocol_cnt++;
            end else if (commit_cnt == 0 && cycle - first_yumi != 3) begin
               $display("mismatch at %0t: first commit latency got %0d expected 3",
                        $time, cycle - first_yumi);
               protocol_cnt++;
            end
            commit_cnt++;
         end
      end
   end

   initial begin
      int   n;
      logic got;
      for (int row = 0; row < rows_p; row++) begin
         n   = 0;
         got = 1'b0;
         while (!got && n < commit_timeout_lp) begin
            @(posedge clk_i);
            got = commit_v_i;
            n++;
         end
         if (!got) begin
            $display("timeout at %0t: no commit arrived for table row %0d", $time, row);
            timeout_cnt++;
         end else begin
            compare_field("commit_pkt_o.pc", dword_t'(commit_pkt_i.pc),
                          dword_t'(instr_tbl_i[row].pc));
            compare_field("commit_pkt_o.op", dword_t'(commit_pkt_i.op),
                          dword_t'(instr_tbl_i[row].op));
            compare_field("commit_pkt_o.rd", dword_t'(commit_pkt_i.rd),
                          dword_t'(instr_tbl_i[row].rd));
            compare_field("commit_pkt_o.data", commit_pkt_i.data, exp_data_i[row]);
         end
      end
      // Extra commits would show up here
      repeat (drain_cycles_lp) @(posedge clk_i);
      @(negedge clk_i);
      compare_field("yumi count", dword_t'(yumi_cnt), dword_t'(rows_p));
      compare_field("commit count", dword_t'(commit_cnt), dword_t'(rows_p));
      done = 1'b1;
   end

   assign done_o         = done;
   assign mismatch_cnt_o = mismatch_cnt;
   assign timeout_cnt_o  = timeout_cnt;
   assign protocol_cnt_o = protocol_cnt;

endmodule
